// File: dcache_tag_check.sv
// Tag compare for one set of the data cache.
// A way matches when it is valid, owned well enough and its tag equals the lookup tag.

`timescale 1ns/1ps

module dcache_tag_check
    import lsq_cfg_pkg::*, stamofu_op_pkg::*;
#(
    parameter int N_WAYS = 2
) (
    input  dcache_tag_t               tag,
    input  logic                      need_exclusive,
    input  dcache_way_t [N_WAYS-1:0]  dcache_resp,
    output logic [N_WAYS-1:0]         vtm_by_way,
    output logic                      any_vtm,
    output logic [$clog2(N_WAYS)-1:0] hit_way
);

    localparam int WAY_W = $clog2(N_WAYS);

    // valid, exclusive if needed, tag match
    always_comb begin
        for (int w = 0; w < N_WAYS; w++) begin
            vtm_by_way[w] = dcache_resp[w].valid
                          & (dcache_resp[w].exclusive | ~need_exclusive)
                          & (dcache_resp[w].tag == tag);
        end
    end

    assign any_vtm = |vtm_by_way;

    // walk down so the lowest matching way wins
    always_comb begin
        hit_way = '0;
        for (int w = N_WAYS - 1; w >= 0; w--) begin
            if (vtm_by_way[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

endmodule

// File: files.f
lsq_cfg_pkg.sv
stamofu_op_pkg.sv
dcache_tag_check.sv
stamofu_req_stage.sv
stamofu_resp_stage.sv
stamofu_launch_top.sv
stamofu_launch_sva.sv
stamofu_launch_tb.sv

// File: lsq_cfg_pkg.sv
// Address, cache geometry and queue sizing for the load-store queue launch path.
// Import into any module that needs one of these widths or vector types.

package lsq_cfg_pkg;

    // -------------------------------------------------------------------------
    // address widths

    // virtual and physical page numbers
    localparam int VPN_WIDTH     = 20;
    localparam int PPN_WIDTH     = 22;

    // page offset and full physical address, both counted in 32-bit words
    localparam int PO_WORD_WIDTH = 10;
    localparam int PA_WORD_WIDTH = 32;

    // -------------------------------------------------------------------------
    // data cache geometry

    localparam int DCACHE_INDEX_WIDTH   = 6;
    localparam int DCACHE_OFFSET_WIDTH  = 5;
    // bank select inside the page-offset word, sits between offset and index
    localparam int DCACHE_BANK_BIT      = 3;
    localparam int DCACHE_TAG_WIDTH     = PPN_WIDTH;
    // room for up to 4 ways in the feedback bundle
    localparam int DCACHE_WAY_IDX_WIDTH = 2;

    // -------------------------------------------------------------------------
    // queue sizing

    localparam int LOG_CQ_ENTRIES  = 3;
    localparam int LOG_ROB_ENTRIES = 7;

    // -------------------------------------------------------------------------
    // vector types

    typedef logic [VPN_WIDTH-1:0]            vpn_t;
    typedef logic [PPN_WIDTH-1:0]            ppn_t;
    typedef logic [PO_WORD_WIDTH-1:0]        po_word_t;
    typedef logic [PA_WORD_WIDTH-1:0]        pa_word_t;
    typedef logic [DCACHE_INDEX_WIDTH-1:0]   dcache_index_t;
    typedef logic [DCACHE_OFFSET_WIDTH-1:0]  dcache_offset_t;
    typedef logic [DCACHE_TAG_WIDTH-1:0]     dcache_tag_t;
    typedef logic [DCACHE_WAY_IDX_WIDTH-1:0] dcache_way_idx_t;
    typedef logic [LOG_CQ_ENTRIES-1:0]       cq_index_t;
    typedef logic [LOG_ROB_ENTRIES-1:0]      rob_index_t;
    typedef logic [3:0]                      byte_mask_t;
    typedef logic [31:0]                     word_t;

endpackage

// File: stamofu_launch_sva.sv
// Handshake timing assertions for the launch pipeline, bound into the top level.

`timescale 1ns/1ps

module stamofu_launch_sva
    import stamofu_op_pkg::*;
(
    input logic       CLK,
    input logic       nRST,
    input logic       req_ack,
    input logic       dtlb_req_valid,
    input logic       cq_ret_valid,
    input dcache_fb_t dcache_fb
);

    int unsigned fail_count = 0;

    // a DTLB lookup only leaves with an accepted operation
    dtlb_req_needs_ack: assert property (
        @(posedge CLK) disable iff (!nRST) dtlb_req_valid |-> req_ack
    ) else begin
        fail_count++;
        $error("DTLB request raised without an acknowledge");
    end

    // fixed one-cycle return latency
    ack_then_return: assert property (
        @(posedge CLK) disable iff (!nRST) req_ack |=> cq_ret_valid
    ) else begin
        fail_count++;
        $error("acknowledged operation not returned in the next cycle");
    end

    hit_miss_exclusive: assert property (
        @(posedge CLK) disable iff (!nRST) !(dcache_fb.hit_valid && dcache_fb.miss_valid)
    ) else begin
        fail_count++;
        $error("cache feedback reports hit and miss together");
    end

endmodule

bind stamofu_launch_top stamofu_launch_sva i_stamofu_launch_sva (
    .CLK            (CLK),
    .nRST           (nRST),
    .req_ack        (req_ack),
    .dtlb_req_valid (dtlb_req_valid),
    .cq_ret_valid   (cq_ret_valid),
    .dcache_fb      (dcache_fb)
);

// File: stamofu_launch_tb.sv
// Testbench for the store/AMO/fence launch pipeline.
// Drives random operations through DTLB and tag response models, predicts each
// central-queue return and compares it in the cycle after acceptance.

`timescale 1ns/1ps

module stamofu_launch_tb
    import lsq_cfg_pkg::*, stamofu_op_pkg::*;
();

    localparam int N_WAYS      = 2;
    localparam int CLK_PERIOD  = 4;
    localparam int N_OPS       = 600;
    localparam int WATCHDOG_NS = N_OPS * CLK_PERIOD * 4;

    typedef struct packed {
        cq_ret_t    ret;
        dcache_fb_t fb;
        logic       aq_valid;
        aq_update_t aq;
    } expect_t;

    logic                     CLK;
    logic                     nRST;
    logic                     req_valid;
    stamofu_req_t             req;
    logic                     req_ack;
    logic                     dtlb_req_valid;
    dtlb_req_t                dtlb_req;
    logic                     dtlb_req_ready;
    dtlb_resp_t               dtlb_resp;
    logic                     dcache_req_valid;
    dcache_req_t              dcache_req;
    logic                     dcache_req_ready;
    dcache_way_t [N_WAYS-1:0] dcache_resp;
    dcache_fb_t               dcache_fb;
    cq_index_t                cq_grab_index;
    cq_grab_t                 cq_grab;
    logic                     cq_ret_valid;
    cq_ret_t                  cq_ret;
    logic                     aq_update_valid;
    aq_update_t               aq_update;

    // central-queue side info per queue slot
    cq_grab_t [(1 << LOG_CQ_ENTRIES)-1:0] grab_table;
    expect_t                              expected_q[$];
    int                                   errors;
    int                                   checks;

    stamofu_launch_top #(.N_WAYS(N_WAYS)) i_stamofu_launch_top (.*);

    assign cq_grab = grab_table[cq_grab_index];

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // ------------------------------------------------------------------------
    // helpers

    task automatic report_mismatch(input string what, input logic [127:0] got,
                                   input logic [127:0] exp);
        errors++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic make_operation(
        input  int                       n,
        output stamofu_req_t             op,
        output dtlb_resp_t               tr,
        output dcache_way_t [N_WAYS-1:0] ways,
        output cq_grab_t                 grab
    );
        int kind;
        kind                    = $urandom % 4;
        op.is_store             = kind < 2;
        op.is_amo               = kind == 2;
        op.is_fence             = kind == 3;
        // about half the AMOs are LR.W
        op.op                   = ($urandom % 2) ? AMO_OP_LR_W : amo_op_t'($urandom);
        op.misaligned_exception = !op.is_fence && ($urandom % 8 == 0);
        op.vpn                  = vpn_t'($urandom);
        op.po_word              = po_word_t'($urandom);
        op.byte_mask            = byte_mask_t'($urandom);
        op.write_data           = $urandom;
        op.cq_index             = cq_index_t'(n);
        tr.hit                  = ($urandom % 4) != 0;
        tr.ppn                  = ppn_t'($urandom);
        tr.is_mem               = $urandom % 2;
        tr.page_fault           = ($urandom % 8) == 0;
        tr.access_fault         = ($urandom % 8) == 0;
        for (int w = 0; w < N_WAYS; w++) begin
            ways[w].valid     = ($urandom % 4) != 0;
            ways[w].exclusive = $urandom % 2;
            ways[w].tag       = dcache_tag_t'($urandom);
        end
        if ($urandom % 2) begin
            ways[$urandom % N_WAYS].tag = tr.ppn;
        end
        // now and then every way carries the tag
        if ($urandom % 8 == 0) begin
            for (int w = 0; w < N_WAYS; w++) begin
                ways[w].tag = tr.ppn;
            end
        end
        grab = cq_grab_t'($urandom);
    endtask

    // expected return, feedback and acquire update of one accepted operation
    function automatic expect_t predict_launch(
        input stamofu_req_t             op,
        input dtlb_resp_t               tr,
        input dcache_way_t [N_WAYS-1:0] ways,
        input cq_grab_t                 grab,
        input logic                     taken
    );
        expect_t e;
        logic    lr_w;
        logic    fault;
        logic    lookup;
        logic    matched;
        e       = '0;
        lr_w    = op.is_amo && op.op == AMO_OP_LR_W;
        fault   = tr.page_fault || tr.access_fault;
        matched = 1'b0;
        e.ret.cq_index             = op.cq_index;
        e.ret.dtlb_hit             = tr.hit;
        e.ret.page_fault           = tr.page_fault;
        e.ret.access_fault         = tr.access_fault;
        e.ret.is_mem               = tr.is_mem;
        e.ret.misaligned_exception = op.misaligned_exception;
        e.ret.byte_mask            = op.byte_mask;
        e.ret.data                 = op.write_data;
        if (op.is_fence || fault || op.misaligned_exception) begin
            e.ret.pa_word = {2'b00, op.vpn, op.po_word};
        end else begin
            e.ret.pa_word = {tr.ppn, op.po_word};
        end
        e.aq_valid   = op.is_amo && tr.hit;
        e.ret.mem_aq = grab.mem_aq & (!e.aq_valid || tr.is_mem);
        e.ret.io_aq  = grab.io_aq & (!e.aq_valid || !tr.is_mem);
        e.ret.mem_rl = grab.mem_rl & (!e.aq_valid || tr.is_mem);
        e.ret.io_rl  = grab.io_rl & (!e.aq_valid || !tr.is_mem);
        e.aq         = {e.ret.mem_aq, e.ret.io_aq, grab.rob_index};
        // shared lines are good enough for LR.W
        lookup = taken && (op.is_store || lr_w) && !op.misaligned_exception
            && tr.hit && !fault;
        for (int w = 0; w < N_WAYS; w++) begin
            if (!matched && ways[w].valid && (ways[w].exclusive || lr_w)
                    && ways[w].tag == tr.ppn) begin
                matched      = 1'b1;
                e.fb.hit_way = dcache_way_idx_t'(w);
            end
        end
        e.fb.hit_valid      = lookup && matched;
        e.fb.miss_valid     = lookup && !matched;
        e.fb.hit_exclusive  = !lr_w;
        e.fb.miss_exclusive = !lr_w;
        e.fb.miss_tag       = tr.ppn;
        return e;
    endfunction

    task automatic check_request_side(input logic valid, input stamofu_req_t op,
                                      input logic ready);
        logic        ack;
        logic        dtlb_v;
        logic        dcache_v;
        dtlb_req_t   exp_dtlb;
        dcache_req_t exp_dc;
        ack      = valid && (ready || op.is_fence || op.misaligned_exception);
        dtlb_v   = ack && !op.is_fence && !op.misaligned_exception;
        dcache_v = ack && !op.misaligned_exception
            && (op.is_store || (op.is_amo && op.op == AMO_OP_LR_W));
        exp_dtlb = {op.vpn, op.cq_index};
        exp_dc   = {op.po_word[2:0], 2'b00, op.po_word[9:4], op.cq_index};
        checks++;
        assert (req_ack == ack) else report_mismatch("req_ack", req_ack, ack);
        assert (dtlb_req_valid == dtlb_v)
            else report_mismatch("dtlb_req_valid", dtlb_req_valid, dtlb_v);
        assert (dcache_req_valid == dcache_v)
            else report_mismatch("dcache_req_valid", dcache_req_valid, dcache_v);
        if (dtlb_v) begin
            assert (dtlb_req == exp_dtlb) else report_mismatch("dtlb_req", dtlb_req, exp_dtlb);
        end
        if (dcache_v) begin
            assert (dcache_req == exp_dc) else report_mismatch("dcache_req", dcache_req, exp_dc);
        end
    endtask

    task automatic check_result(input expect_t e);
        checks++;
        assert (cq_grab_index == e.ret.cq_index)
            else report_mismatch("cq_grab_index", cq_grab_index, e.ret.cq_index);
        assert (cq_ret == e.ret) else report_mismatch("cq_ret", cq_ret, e.ret);
        assert ({dcache_fb.hit_valid, dcache_fb.miss_valid} == {e.fb.hit_valid, e.fb.miss_valid})
            else report_mismatch("hit/miss valid", {dcache_fb.hit_valid, dcache_fb.miss_valid},
                                 {e.fb.hit_valid, e.fb.miss_valid});
        if (e.fb.hit_valid) begin
            assert ({dcache_fb.hit_way, dcache_fb.hit_exclusive}
                    == {e.fb.hit_way, e.fb.hit_exclusive})
                else report_mismatch("hit way", dcache_fb.hit_way, e.fb.hit_way);
        end
        if (e.fb.miss_valid) begin
            assert ({dcache_fb.miss_tag, dcache_fb.miss_exclusive}
                    == {e.fb.miss_tag, e.fb.miss_exclusive})
                else report_mismatch("miss tag", dcache_fb.miss_tag, e.fb.miss_tag);
        end
        assert (aq_update_valid == e.aq_valid)
            else report_mismatch("aq_update_valid", aq_update_valid, e.aq_valid);
        if (e.aq_valid) begin
            assert (aq_update == e.aq) else report_mismatch("aq_update", aq_update, e.aq);
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus and response models

    initial begin : drive
        stamofu_req_t             op;
        dtlb_resp_t               tr;
        dcache_way_t [N_WAYS-1:0] ways;
        cq_grab_t                 grab;
        logic                     acked;
        logic                     taken;
        void'($urandom(32'hdfa9));
        errors           = 0;
        checks           = 0;
        nRST             = 1'b0;
        req_valid        = 1'b0;
        req              = '0;
        dtlb_req_ready   = 1'b0;
        dtlb_resp        = '0;
        dcache_req_ready = 1'b0;
        dcache_resp      = '0;
        grab_table       = '0;
        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;
        for (int n = 0; n < N_OPS; n++) begin
            make_operation(n, op, tr, ways, grab);
            grab_table[op.cq_index] = grab;
            acked = 1'b0;
            while (!acked) begin
                // idle now and then and DTLB busy a quarter of the time
                req_valid        = ($urandom % 8) != 0;
                req              = op;
                dtlb_req_ready   = ($urandom % 4) != 0;
                dcache_req_ready = ($urandom % 4) != 0;
                @(negedge CLK);
                check_request_side(req_valid, op, dtlb_req_ready);
                acked = req_ack;
                taken = dcache_req_ready;
                @(posedge CLK);
                #1;
                // responses arrive the cycle after the request
                dtlb_resp   = (acked && !op.is_fence && !op.misaligned_exception) ? tr : '0;
                dcache_resp = ways;
                if (acked) begin
                    expected_q.push_back(predict_launch(op, dtlb_resp, ways, grab, taken));
                end
            end
        end
        req_valid = 1'b0;
        repeat (3) @(negedge CLK);
        errors += i_stamofu_launch_top.i_stamofu_launch_sva.fail_count;
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // ------------------------------------------------------------------------
    // compare and watchdog

    initial begin : compare
        expect_t e;
        forever begin
            @(negedge CLK);
            if (cq_ret_valid) begin
                assert (expected_q.size() != 0) else begin
                    errors++;
                    $display("%0t: return valid with no accepted operation pending", $time);
                end
                if (expected_q.size() != 0) begin
                    e = expected_q.pop_front();
                    check_result(e);
                end
            end else begin
                assert (expected_q.size() == 0) else begin
                    errors++;
                    $display("%0t: accepted operation was not returned", $time);
                    expected_q.delete();
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: run did not complete, %0d errors so far", errors);
        $display("Errors found");
        $finish;
    end

endmodule

// File: stamofu_launch_top.sv
// Top of the store/AMO/fence launch pipeline.
// Connects the REQ stage to the RESP stage through the launch register.

`timescale 1ns/1ps

module stamofu_launch_top
    import lsq_cfg_pkg::*, stamofu_op_pkg::*;
#(
    parameter int N_WAYS = 2
) (
    input  logic                     CLK,
    input  logic                     nRST,

    // operation from the central queue
    input  logic                     req_valid,
    input  stamofu_req_t             req,
    output logic                     req_ack,

    // DTLB
    output logic                     dtlb_req_valid,
    output dtlb_req_t                dtlb_req,
    input  logic                     dtlb_req_ready,
    input  dtlb_resp_t               dtlb_resp,

    // data cache
    output logic                     dcache_req_valid,
    output dcache_req_t              dcache_req,
    input  logic                     dcache_req_ready,
    input  dcache_way_t [N_WAYS-1:0] dcache_resp,
    output dcache_fb_t               dcache_fb,

    // central queue info
    output cq_index_t                cq_grab_index,
    input  cq_grab_t                 cq_grab,
    output logic                     cq_ret_valid,
    output cq_ret_t                  cq_ret,

    // acquire update
    output logic                     aq_update_valid,
    output aq_update_t               aq_update
);

    launch_op_t launch_op;

    stamofu_req_stage i_stamofu_req_stage (
        .CLK              (CLK),
        .nRST             (nRST),
        .req_valid        (req_valid),
        .req              (req),
        .req_ack          (req_ack),
        .dtlb_req_valid   (dtlb_req_valid),
        .dtlb_req         (dtlb_req),
        .dtlb_req_ready   (dtlb_req_ready),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req       (dcache_req),
        .dcache_req_ready (dcache_req_ready),
        .launch_op        (launch_op)
    );

    stamofu_resp_stage #(
        .N_WAYS (N_WAYS)
    ) i_stamofu_resp_stage (
        .launch_op       (launch_op),
        .dtlb_resp       (dtlb_resp),
        .dcache_resp     (dcache_resp),
        .cq_grab_index   (cq_grab_index),
        .cq_grab         (cq_grab),
        .dcache_fb       (dcache_fb),
        .cq_ret_valid    (cq_ret_valid),
        .cq_ret          (cq_ret),
        .aq_update_valid (aq_update_valid),
        .aq_update       (aq_update)
    );

endmodule

// File: stamofu_op_pkg.sv
// Operation encoding and the bundles exchanged by the store/AMO/fence launch pipeline.
// Covers the central-queue ports, the DTLB and data-cache ports and the stage register.

package stamofu_op_pkg;

    import lsq_cfg_pkg::*;

    typedef logic [3:0] amo_op_t;

    // only AMO encoding the launch path cares about
    localparam amo_op_t AMO_OP_LR_W = 4'b0010;

    // -------------------------------------------------------------------------
    // operation from the central queue and the REQ-to-RESP register

    typedef struct packed {
        logic       is_store;
        logic       is_amo;
        logic       is_fence;
        amo_op_t    op;
        logic       misaligned_exception;
        vpn_t       vpn;
        po_word_t   po_word;
        byte_mask_t byte_mask;
        word_t      write_data;
        cq_index_t  cq_index;
    } stamofu_req_t;

    typedef struct packed {
        logic         valid;
        stamofu_req_t req;
        // low only for LR.W, which can live with a shared line
        logic         exclusive;
        logic         prefetch;
    } launch_op_t;

    // -------------------------------------------------------------------------
    // DTLB and data cache

    typedef struct packed {
        vpn_t      vpn;
        cq_index_t cq_index;
    } dtlb_req_t;

    typedef struct packed {
        logic hit;
        ppn_t ppn;
        logic is_mem;
        logic page_fault;
        logic access_fault;
    } dtlb_resp_t;

    typedef struct packed {
        dcache_offset_t block_offset;
        dcache_index_t  index;
        cq_index_t      cq_index;
    } dcache_req_t;

    // one way of the tag response, ports carry a packed array of these
    typedef struct packed {
        logic        valid;
        logic        exclusive;
        dcache_tag_t tag;
    } dcache_way_t;

    typedef struct packed {
        logic            hit_valid;
        logic            hit_exclusive;
        dcache_way_idx_t hit_way;
        logic            miss_valid;
        logic            miss_exclusive;
        dcache_tag_t     miss_tag;
    } dcache_fb_t;

    // -------------------------------------------------------------------------
    // central queue and acquire tracking

    typedef struct packed {
        logic       mem_aq;
        logic       io_aq;
        logic       mem_rl;
        logic       io_rl;
        rob_index_t rob_index;
    } cq_grab_t;

    typedef struct packed {
        cq_index_t  cq_index;
        logic       dtlb_hit;
        logic       page_fault;
        logic       access_fault;
        logic       is_mem;
        logic       mem_aq;
        logic       io_aq;
        logic       mem_rl;
        logic       io_rl;
        logic       misaligned_exception;
        pa_word_t   pa_word;
        byte_mask_t byte_mask;
        word_t      data;
    } cq_ret_t;

    typedef struct packed {
        logic       mem_aq;
        logic       io_aq;
        rob_index_t rob_index;
    } aq_update_t;

endpackage

// File: stamofu_req_stage.sv
// REQ stage of the store/AMO/fence launch pipeline.
// Accepts one operation per cycle, fires the DTLB lookup and the tag prefetch,
// and registers the operation for the RESP stage.

`timescale 1ns/1ps

module stamofu_req_stage
    import lsq_cfg_pkg::*, stamofu_op_pkg::*;
(
    input  logic         CLK,
    input  logic         nRST,

    // operation from the central queue
    input  logic         req_valid,
    input  stamofu_req_t req,
    output logic         req_ack,

    // DTLB lookup
    output logic         dtlb_req_valid,
    output dtlb_req_t    dtlb_req,
    input  logic         dtlb_req_ready,

    // data-cache tag prefetch
    output logic         dcache_req_valid,
    output dcache_req_t  dcache_req,
    input  logic         dcache_req_ready,

    // to RESP stage
    output launch_op_t   launch_op
);

    logic         is_lr_w;
    logic         needs_dtlb;
    logic         prefetch_req;

    logic         valid_q;
    logic         exclusive_q;
    logic         prefetch_q;
    stamofu_req_t req_q;

    // -------------------------------------------------------------------------
    // acceptance

    assign is_lr_w = req.is_amo & (req.op == AMO_OP_LR_W);

    // fences and misaligned exceptions skip translation
    assign needs_dtlb = ~req.is_fence & ~req.misaligned_exception;

    // DTLB ready only matters when a lookup is actually sent
    assign req_ack = req_valid & (dtlb_req_ready | ~needs_dtlb);

    assign dtlb_req_valid = req_ack & needs_dtlb;

    // only stores and LR.W warm up the tags
    assign prefetch_req = req_ack & (req.is_store | is_lr_w) & ~req.misaligned_exception;

    assign dcache_req_valid = prefetch_req;

    // -------------------------------------------------------------------------
    // request payloads

    always_comb begin
        dtlb_req.vpn      = req.vpn;
        dtlb_req.cq_index = req.cq_index;

        // word within the block, then byte zero of that word
        dcache_req.block_offset = {req.po_word[DCACHE_BANK_BIT-1:0], 2'b00};
        // bank bit is left out, each bank has its own pipe
        dcache_req.index    = req.po_word[DCACHE_INDEX_WIDTH+DCACHE_BANK_BIT:DCACHE_BANK_BIT+1];
        dcache_req.cq_index = req.cq_index;
    end

    // -------------------------------------------------------------------------
    // REQ-to-RESP register

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q     <= 1'b0;
            exclusive_q <= 1'b1;
            prefetch_q  <= 1'b0;
        end else begin
            valid_q     <= req_ack;
            exclusive_q <= ~is_lr_w;
            // a prefetch the cache did not take gets no hit/miss later
            prefetch_q  <= prefetch_req & dcache_req_ready;
        end
    end

    always_ff @(posedge CLK) begin
        if (req_ack) begin
            req_q <= req;
        end
    end

    assign launch_op = '{
        valid:     valid_q,
        req:       req_q,
        exclusive: exclusive_q,
        prefetch:  prefetch_q
    };

endmodule

// File: stamofu_resp_stage.sv
// RESP stage of the store/AMO/fence launch pipeline.
// Combines the registered operation with the DTLB and tag responses, returns the
// result to the central queue and sends the cache feedback and acquire update.

`timescale 1ns/1ps

module stamofu_resp_stage
    import lsq_cfg_pkg::*, stamofu_op_pkg::*;
#(
    parameter int N_WAYS = 2
) (
    input  launch_op_t               launch_op,
    input  dtlb_resp_t               dtlb_resp,
    input  dcache_way_t [N_WAYS-1:0] dcache_resp,

    // central queue side info, answered in the same cycle
    output cq_index_t                cq_grab_index,
    input  cq_grab_t                 cq_grab,

    output dcache_fb_t               dcache_fb,
    output logic                     cq_ret_valid,
    output cq_ret_t                  cq_ret,
    output logic                     aq_update_valid,
    output aq_update_t               aq_update
);

    stamofu_req_t              op;
    logic                      fault;
    logic                      use_vaddr;
    logic                      lookup;
    logic                      amo_known;
    pa_word_t                  pa_word;
    pa_word_t                  ret_word;
    dcache_tag_t               tag;
    logic [N_WAYS-1:0]         vtm_by_way;
    logic                      any_vtm;
    logic [$clog2(N_WAYS)-1:0] hit_way;

    assign op = launch_op.req;

    assign cq_grab_index = op.cq_index;

    // -------------------------------------------------------------------------
    // address formation

    assign fault   = dtlb_resp.page_fault | dtlb_resp.access_fault;
    assign pa_word = {dtlb_resp.ppn, op.po_word};
    assign tag     = pa_word[PA_WORD_WIDTH-1 -: DCACHE_TAG_WIDTH];

    // SFENCE.VMA and anything that traps hand back the virtual address instead
    assign use_vaddr = op.is_fence | fault | op.misaligned_exception;
    assign ret_word  = use_vaddr
        ? {{(PA_WORD_WIDTH - VPN_WIDTH - PO_WORD_WIDTH){1'b0}}, op.vpn, op.po_word}
        : pa_word;

    // -------------------------------------------------------------------------
    // tag check and cache feedback

    dcache_tag_check #(
        .N_WAYS (N_WAYS)
    ) i_dcache_tag_check (
        .tag            (tag),
        .need_exclusive (launch_op.exclusive),
        .dcache_resp    (dcache_resp),
        .vtm_by_way     (vtm_by_way),
        .any_vtm        (any_vtm),
        .hit_way        (hit_way)
    );

    // only a prefetch that went out and translated cleanly gets an answer
    assign lookup = launch_op.valid & launch_op.prefetch & dtlb_resp.hit & ~fault;

    always_comb begin
        dcache_fb.hit_valid      = lookup & any_vtm;
        dcache_fb.hit_exclusive  = launch_op.exclusive;
        dcache_fb.hit_way        = dcache_way_idx_t'(hit_way);
        dcache_fb.miss_valid     = lookup & (vtm_by_way == '0);
        dcache_fb.miss_exclusive = launch_op.exclusive;
        dcache_fb.miss_tag       = tag;
    end

    // -------------------------------------------------------------------------
    // central queue return and acquire update

    // mem vs io is only known once the DTLB hits
    assign amo_known = op.is_amo & dtlb_resp.hit;

    assign cq_ret_valid = launch_op.valid;

    always_comb begin
        cq_ret.cq_index     = op.cq_index;
        cq_ret.dtlb_hit     = dtlb_resp.hit;
        cq_ret.page_fault   = dtlb_resp.page_fault;
        cq_ret.access_fault = dtlb_resp.access_fault;
        cq_ret.is_mem       = dtlb_resp.is_mem;
        if (amo_known) begin
            cq_ret.mem_aq = cq_grab.mem_aq & dtlb_resp.is_mem;
            cq_ret.io_aq  = cq_grab.io_aq & ~dtlb_resp.is_mem;
            cq_ret.mem_rl = cq_grab.mem_rl & dtlb_resp.is_mem;
            cq_ret.io_rl  = cq_grab.io_rl & ~dtlb_resp.is_mem;
        end else begin
            cq_ret.mem_aq = cq_grab.mem_aq;
            cq_ret.io_aq  = cq_grab.io_aq;
            cq_ret.mem_rl = cq_grab.mem_rl;
            cq_ret.io_rl  = cq_grab.io_rl;
        end
        cq_ret.misaligned_exception = op.misaligned_exception;
        cq_ret.pa_word              = ret_word;
        cq_ret.byte_mask            = op.byte_mask;
        cq_ret.data                 = op.write_data;
    end

    assign aq_update_valid = launch_op.valid & amo_known;

    always_comb begin
        aq_update.mem_aq    = cq_grab.mem_aq & dtlb_resp.is_mem;
        aq_update.io_aq     = cq_grab.io_aq & ~dtlb_resp.is_mem;
        aq_update.rob_index = cq_grab.rob_index;
    end

endmodule
